/* common/sd_pkg.sv */
package sd_pkg;

	localparam int id_clk_div = 250;       // sys_clk cycles per slow sd_clk period
	localparam int ms_ticks = 400;         // slow periods per ms
	localparam int rsp_timeout_ticks = 80; // bit times before giving up on a response
	localparam int ncc_ticks = 15;         // idle bits after CMD0
	localparam int data_timeout_ms = 2;
	localparam int block_bytes = 512;

	typedef logic [5:0] cmd_index_t;
	typedef logic [31:0] cmd_arg_t;
	typedef logic [45:0] rsp_short_t;  // index/arg/crc/end, no start bits
	typedef logic [15:0] rca_t;
	typedef logic [31:0] block_addr_t;
	typedef logic [7:0] sd_byte_t;

	typedef enum logic {tx_idle, tx_send} cmd_tx_state_t;

	typedef enum logic [1:0] {rx_idle, rx_hunt, rx_shift, rx_trail} cmd_rx_state_t;

	typedef enum logic [1:0] {dr_idle, dr_hunt, dr_shift, dr_trail} dat_rx_state_t;

	// one state per command, plus the non-command waits
	typedef enum logic [3:0] {
		cs_cmd0,
		cs_ncc,
		cs_cmd8,
		cs_app41,
		cs_acmd41,
		cs_cmd2,
		cs_cmd3,
		cs_cmd7,
		cs_app6,
		cs_acmd6,
		cs_ready,
		cs_cmd17,
		cs_read,
		cs_halt
	} ctrl_state_t;

	typedef enum logic [1:0] {ph_issue, ph_cmd, ph_rsp} ctrl_phase_t;

endpackage

/* src/sd_clock_gen.sv */
`timescale 1ns/1ps

module sd_clock_gen (
	input  logic sys_clk,
	input  logic rst,
	input  logic fast_mode,
	output logic sd_clk,
	output logic fall_tick,
	output logic rise_tick,
	output logic ms_tick
);

	logic [$clog2(sd_pkg::id_clk_div)-1:0] id_cnt;
	logic [$clog2(sd_pkg::ms_ticks)-1:0] ms_cnt;
	logic id_wrap;
	logic edge_now;

	assign id_wrap = (id_cnt == sd_pkg::id_clk_div - 1);
	// in fast mode sd_clk toggles every cycle
	assign edge_now = fast_mode || id_wrap || (id_cnt == sd_pkg::id_clk_div / 2 - 1);
	assign fall_tick = edge_now && sd_clk;  // sd_clk drops on the next edge
	assign rise_tick = edge_now && !sd_clk;

	always_ff @(posedge sys_clk)
	begin
		if (rst)
		begin
			id_cnt <= '0;
			ms_cnt <= '0;
			ms_tick <= 1'b0;
			sd_clk <= 1'b0;
		end
		else
		begin
			id_cnt <= id_wrap ? '0 : id_cnt + 1'b1;
			ms_tick <= 1'b0;
			if (id_wrap)
			begin
				if (ms_cnt == sd_pkg::ms_ticks - 1)
				begin
					ms_cnt <= '0;
					ms_tick <= 1'b1;
				end
				else
					ms_cnt <= ms_cnt + 1'b1;
			end
			if (edge_now)
				sd_clk <= ~sd_clk;
		end
	end

endmodule

/* sd_cmd/sd_cmd_tx.sv */
`timescale 1ns/1ps

module sd_cmd_tx (
	input  logic sys_clk,
	input  logic rst,
	input  logic fall_tick,
	input  logic cmd_start,
	input  sd_pkg::cmd_index_t cmd_index,
	input  sd_pkg::cmd_arg_t cmd_arg,
	output logic cmd_done,
	output logic cmd_oe,
	output logic cmd_out
);

	sd_pkg::cmd_tx_state_t state;
	logic [39:0] frame;  // start, transmission, index, argument
	logic [6:0] crc;
	logic [5:0] bit_cnt;
	logic crc_fb;

	assign crc_fb = frame[39] ^ crc[6];

	always_ff @(posedge sys_clk)
	begin
		if (rst)
		begin
			state <= sd_pkg::tx_idle;
			bit_cnt <= '0;
			cmd_done <= 1'b0;
			cmd_oe <= 1'b0;
			cmd_out <= 1'b1;
		end
		else
		begin
			cmd_done <= 1'b0;
			case (state)
				sd_pkg::tx_idle:
					if (cmd_start)
					begin
						frame <= {2'b01, cmd_index, cmd_arg};
						crc <= '0;
						bit_cnt <= '0;
						state <= sd_pkg::tx_send;
					end
				sd_pkg::tx_send:
					if (fall_tick)
					begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 6'd48)
						begin
							cmd_oe <= 1'b0;  // last bit has had its full period
							cmd_out <= 1'b1;
							cmd_done <= 1'b1;
							state <= sd_pkg::tx_idle;
						end
						else if (bit_cnt < 6'd40)
						begin
							cmd_oe <= 1'b1;
							cmd_out <= frame[39];
							frame <= {frame[38:0], 1'b0};
							crc <= {crc[5:0], crc_fb} ^ {3'b000, crc_fb, 3'b000};  // x^7+x^3+1
						end
						else if (bit_cnt < 6'd47)
						begin
							cmd_out <= crc[6];
							crc <= {crc[5:0], 1'b0};
						end
						else
							cmd_out <= 1'b1;  // end bit
					end
				default:
					state <= sd_pkg::tx_idle;
			endcase
		end
	end

endmodule

/* sd_cmd/sd_cmd_rx.sv */
`timescale 1ns/1ps

module sd_cmd_rx (
	input  logic sys_clk,
	input  logic rst,
	input  logic rise_tick,
	input  logic rsp_start,
	input  logic rsp_long,
	input  logic cmd_in,
	output logic rsp_done,
	output logic rsp_timeout,
	output sd_pkg::rsp_short_t rsp_short
);

	sd_pkg::cmd_rx_state_t state;
	sd_pkg::rsp_short_t shift;  // long responses keep only the tail
	logic [7:0] cnt;
	logic [7:0] last_bit;
	logic long_rsp;
	logic seen_zero;

	assign last_bit = long_rsp ? 8'd133 : 8'd45;

	always_ff @(posedge sys_clk)
	begin
		if (rst)
		begin
			state <= sd_pkg::rx_idle;
			cnt <= '0;
			long_rsp <= 1'b0;
			seen_zero <= 1'b0;
			rsp_done <= 1'b0;
			rsp_timeout <= 1'b0;
		end
		else
		begin
			rsp_done <= 1'b0;
			case (state)
				sd_pkg::rx_idle:
					if (rsp_start)
					begin
						long_rsp <= rsp_long;
						rsp_timeout <= 1'b0;
						seen_zero <= 1'b0;
						cnt <= '0;
						state <= sd_pkg::rx_hunt;
					end
				sd_pkg::rx_hunt:
					if (rise_tick)
					begin
						if (seen_zero && !cmd_in)  // start and transmission bits
						begin
							cnt <= '0;
							state <= sd_pkg::rx_shift;
						end
						else if (cnt == sd_pkg::rsp_timeout_ticks - 1)
						begin
							rsp_timeout <= 1'b1;
							rsp_done <= 1'b1;
							state <= sd_pkg::rx_idle;
						end
						else
						begin
							cnt <= cnt + 1'b1;
							seen_zero <= !cmd_in;
						end
					end
				sd_pkg::rx_shift:
					if (rise_tick)
					begin
						shift <= {shift[44:0], cmd_in};
						cnt <= (cnt == last_bit) ? 8'd0 : cnt + 1'b1;
						if (cnt == last_bit)
							state <= sd_pkg::rx_trail;
					end
				sd_pkg::rx_trail:
					if (rise_tick)
					begin
						// 8 idle bits before the next command may go out
						if (cnt == 8'd7)
						begin
							rsp_short <= shift;
							rsp_done <= 1'b1;
							state <= sd_pkg::rx_idle;
						end
						else
							cnt <= cnt + 1'b1;
					end
				default:
					state <= sd_pkg::rx_idle;
			endcase
		end
	end

endmodule

/* sd_dat/sd_dat_rx.sv */
`timescale 1ns/1ps

module sd_dat_rx (
	input  logic sys_clk,
	input  logic rst,
	input  logic rise_tick,
	input  logic ms_tick,
	input  logic dat_start,
	input  logic [3:0] dat_in,
	output logic dat_done,
	output logic dat_timeout,
	output logic data_valid,
	output sd_pkg::sd_byte_t data_byte
);

	sd_pkg::dat_rx_state_t state;
	logic [$clog2(2 * sd_pkg::block_bytes)-1:0] cnt;  // nibbles, then trailing bits
	logic [$clog2(sd_pkg::data_timeout_ms + 1)-1:0] ms_cnt;
	logic [3:0] high_nib;

	always_ff @(posedge sys_clk)
	begin
		if (rst)
		begin
			state <= sd_pkg::dr_idle;
			cnt <= '0;
			ms_cnt <= '0;
			dat_done <= 1'b0;
			dat_timeout <= 1'b0;
			data_valid <= 1'b0;
		end
		else
		begin
			dat_done <= 1'b0;
			data_valid <= 1'b0;
			case (state)
				sd_pkg::dr_idle:
					if (dat_start)
					begin
						dat_timeout <= 1'b0;
						ms_cnt <= '0;
						cnt <= '0;
						state <= sd_pkg::dr_hunt;
					end
				sd_pkg::dr_hunt:
					if (rise_tick && dat_in == 4'h0)  // start bit on all four lines
						state <= sd_pkg::dr_shift;
					else if (ms_tick)
					begin
						if (ms_cnt == sd_pkg::data_timeout_ms - 1)
						begin
							dat_timeout <= 1'b1;
							dat_done <= 1'b1;
							state <= sd_pkg::dr_idle;
						end
						else
							ms_cnt <= ms_cnt + 1'b1;
					end
				sd_pkg::dr_shift:
					if (rise_tick)
					begin
						cnt <= cnt + 1'b1;
						if (!cnt[0])
							high_nib <= dat_in;  // high nibble first
						else
						begin
							data_byte <= {high_nib, dat_in};
							data_valid <= 1'b1;
						end
						if (cnt == 2 * sd_pkg::block_bytes - 1)
							state <= sd_pkg::dr_trail;  // cnt wraps to 0 here
					end
				sd_pkg::dr_trail:
					if (rise_tick)
					begin
						// crc16 per line and the end bit, not checked
						if (cnt == 16)
						begin
							dat_done <= 1'b1;
							state <= sd_pkg::dr_idle;
						end
						else
							cnt <= cnt + 1'b1;
					end
				default:
					state <= sd_pkg::dr_idle;
			endcase
		end
	end

endmodule

/* src/sd_card_ctrl.sv */
`timescale 1ns/1ps

module sd_card_ctrl (
	input  logic sys_clk,
	input  logic rst,
	input  logic fall_tick,
	input  logic init_req,
	input  logic read_req,
	input  sd_pkg::block_addr_t block_addr,
	output logic cmd_start,
	output sd_pkg::cmd_index_t cmd_index,
	output sd_pkg::cmd_arg_t cmd_arg,
	input  logic cmd_done,
	output logic rsp_start,
	output logic rsp_long,
	input  logic rsp_done,
	input  logic rsp_timeout,
	input  sd_pkg::rsp_short_t rsp_short,
	output logic dat_start,
	input  logic dat_done,
	input  logic dat_timeout,
	output logic fast_mode,
	output logic card_ready,
	output logic read_done,
	output logic read_error,
	output logic card_error
);

	sd_pkg::ctrl_state_t state;
	sd_pkg::ctrl_phase_t phase;
	logic [$clog2(sd_pkg::ncc_ticks)-1:0] ncc_cnt;
	logic v2;        // card answered CMD8
	logic v1_retry;  // second CMD0 on the v1 path
	logic hc;        // high capacity, block addressing
	sd_pkg::rca_t rca;
	sd_pkg::cmd_arg_t rd_arg;
	logic app_ok;

	assign rsp_long = (state == sd_pkg::cs_cmd2);
	assign app_ok = (rsp_short[45:40] == 6'd55) && rsp_short[13];  // APP_CMD echoed

	always_comb
	begin
		cmd_arg = '0;
		case (state)
			sd_pkg::cs_cmd8: cmd_arg = {20'h0, 4'h1, 8'haa};  // 2.7-3.6V, check pattern
			sd_pkg::cs_acmd41: cmd_arg = {1'b0, v2, 6'b0, 24'hff8000};
			sd_pkg::cs_cmd7, sd_pkg::cs_app6: cmd_arg = {rca, 16'h0};
			sd_pkg::cs_acmd6: cmd_arg = 32'd2;  // 4-bit bus
			sd_pkg::cs_cmd17: cmd_arg = rd_arg;
			default: cmd_arg = '0;
		endcase
		case (state)
			sd_pkg::cs_cmd8: cmd_index = 6'd8;
			sd_pkg::cs_app41, sd_pkg::cs_app6: cmd_index = 6'd55;
			sd_pkg::cs_acmd41: cmd_index = 6'd41;
			sd_pkg::cs_cmd2: cmd_index = 6'd2;
			sd_pkg::cs_cmd3: cmd_index = 6'd3;
			sd_pkg::cs_cmd7: cmd_index = 6'd7;
			sd_pkg::cs_acmd6: cmd_index = 6'd6;
			sd_pkg::cs_cmd17: cmd_index = 6'd17;
			default: cmd_index = 6'd0;
		endcase
	end

	always_ff @(posedge sys_clk)
	begin
		if (rst || init_req)
		begin
			state <= sd_pkg::cs_cmd0;
			phase <= sd_pkg::ph_issue;
			ncc_cnt <= '0;
			v2 <= 1'b0;
			v1_retry <= 1'b0;
			hc <= 1'b0;
			cmd_start <= 1'b0;
			rsp_start <= 1'b0;
			dat_start <= 1'b0;
			fast_mode <= 1'b0;
			card_ready <= 1'b0;
			read_done <= 1'b0;
			read_error <= 1'b0;
			card_error <= 1'b0;
		end
		else
		begin
			cmd_start <= 1'b0;
			rsp_start <= 1'b0;
			dat_start <= 1'b0;
			read_done <= 1'b0;
			read_error <= 1'b0;
			case (state)
				sd_pkg::cs_ncc:
					if (fall_tick)
					begin
						ncc_cnt <= (ncc_cnt == sd_pkg::ncc_ticks - 1) ? '0 : ncc_cnt + 1'b1;
						if (ncc_cnt == sd_pkg::ncc_ticks - 1)
							state <= v1_retry ? sd_pkg::cs_app41 : sd_pkg::cs_cmd8;
					end
				sd_pkg::cs_ready:
					if (read_req)
					begin
						// standard cards take a byte address
						rd_arg <= hc ? block_addr : {block_addr[22:0], 9'd0};
						card_ready <= 1'b0;
						state <= sd_pkg::cs_cmd17;
					end
				sd_pkg::cs_read:
					if (dat_done)
					begin
						read_done <= 1'b1;
						read_error <= dat_timeout;
						card_ready <= 1'b1;
						state <= sd_pkg::cs_ready;
					end
				sd_pkg::cs_halt:
					card_error <= 1'b1;  // stays here until init_req
				default:
					case (phase)
						sd_pkg::ph_issue:
						begin
							cmd_start <= 1'b1;
							phase <= sd_pkg::ph_cmd;
						end
						sd_pkg::ph_cmd:
							if (cmd_done)
							begin
								rsp_start <= (state != sd_pkg::cs_cmd0);
								if (state == sd_pkg::cs_cmd0)
								begin
									phase <= sd_pkg::ph_issue;
									state <= sd_pkg::cs_ncc;  // CMD0 has no response
								end
								else if (state == sd_pkg::cs_cmd17)
								begin
									dat_start <= 1'b1;  // data may start right after the command
									phase <= sd_pkg::ph_issue;
									state <= sd_pkg::cs_read;
								end
								else
									phase <= sd_pkg::ph_rsp;
							end
						default:
							if (rsp_done)
							begin
								phase <= sd_pkg::ph_issue;
								if (rsp_timeout && state != sd_pkg::cs_cmd8)
								begin
									// lost the card, start over
									v1_retry <= 1'b0;
									fast_mode <= 1'b0;
									state <= sd_pkg::cs_cmd0;
								end
								else
									case (state)
										sd_pkg::cs_cmd8:
											if (rsp_timeout)
											begin
												v2 <= 1'b0;
												v1_retry <= 1'b1;
												state <= sd_pkg::cs_cmd0;
											end
											else if (rsp_short[45:40] == 6'd8 && rsp_short[19:16] == 4'h1
												&& rsp_short[15:8] == 8'haa)
											begin
												v2 <= 1'b1;
												state <= sd_pkg::cs_app41;
											end
											else
												state <= sd_pkg::cs_halt;
										sd_pkg::cs_app41:
											state <= app_ok ? sd_pkg::cs_acmd41 : sd_pkg::cs_halt;
										sd_pkg::cs_acmd41:
										begin
											hc <= rsp_short[38];  // OCR CCS
											// busy bit low means still powering up
											state <= rsp_short[39] ? sd_pkg::cs_cmd2 : sd_pkg::cs_app41;
										end
										sd_pkg::cs_cmd2:
											state <= sd_pkg::cs_cmd3;
										sd_pkg::cs_cmd3:
										begin
											rca <= rsp_short[39:24];
											fast_mode <= 1'b1;
											state <= sd_pkg::cs_cmd7;
										end
										sd_pkg::cs_cmd7:
											state <= sd_pkg::cs_app6;
										sd_pkg::cs_app6:
											state <= app_ok ? sd_pkg::cs_acmd6 : sd_pkg::cs_halt;
										default:
										begin
											card_ready <= 1'b1;  // ACMD6 answered
											state <= sd_pkg::cs_ready;
										end
									endcase
							end
					endcase
			endcase
		end
	end

endmodule

/* src/sd_host_top.sv */
`timescale 1ns/1ps

module sd_host_top (
	input  logic sys_clk,
	input  logic rst,
	input  logic init_req,
	input  logic read_req,
	input  sd_pkg::block_addr_t block_addr,
	output logic card_ready,
	output logic card_error,
	output logic data_valid,
	output logic read_done,
	output logic read_error,
	output logic sd_clk,
	output sd_pkg::sd_byte_t data_byte,
	inout  wire sd_cmd,
	inout  wire [3:0] sd_dat
);

	logic fast_mode;
	logic fall_tick;
	logic rise_tick;
	logic ms_tick;
	logic cmd_start;
	sd_pkg::cmd_index_t cmd_index;
	sd_pkg::cmd_arg_t cmd_arg;
	logic cmd_done;
	logic cmd_oe;
	logic cmd_out;
	logic rsp_start;
	logic rsp_long;
	logic rsp_done;
	logic rsp_timeout;
	sd_pkg::rsp_short_t rsp_short;
	logic dat_start;
	logic dat_done;
	logic dat_timeout;

	assign sd_cmd = cmd_oe ? cmd_out : 1'bz;  // pulled up on the board

	sd_clock_gen u_clock_gen (.sys_clk, .rst, .fast_mode, .sd_clk, .fall_tick, .rise_tick,
		.ms_tick);

	sd_card_ctrl u_card_ctrl (.sys_clk, .rst, .fall_tick, .init_req, .read_req, .block_addr,
		.cmd_start, .cmd_index, .cmd_arg, .cmd_done, .rsp_start, .rsp_long, .rsp_done,
		.rsp_timeout, .rsp_short, .dat_start, .dat_done, .dat_timeout, .fast_mode,
		.card_ready, .read_done, .read_error, .card_error);

	sd_cmd_tx u_cmd_tx (.sys_clk, .rst, .fall_tick, .cmd_start, .cmd_index, .cmd_arg,
		.cmd_done, .cmd_oe, .cmd_out);

	sd_cmd_rx u_cmd_rx (.sys_clk, .rst, .rise_tick, .rsp_start, .rsp_long, .cmd_in(sd_cmd),
		.rsp_done, .rsp_timeout, .rsp_short);

	// read only, the host never drives the data lines
	sd_dat_rx u_dat_rx (.sys_clk, .rst, .rise_tick, .ms_tick, .dat_start, .dat_in(sd_dat),
		.dat_done, .dat_timeout, .data_valid, .data_byte);

endmodule

/* tb/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
	output logic sys_clk,
	output logic rst
);

	initial
	begin
		sys_clk = 1'b0;
		rst = 1'b1;
		repeat (3) @(posedge sys_clk);
		@(negedge sys_clk);
		rst = 1'b0;  // released on a falling edge
	end

	always #4 sys_clk = ~sys_clk;  // 8 ns period

endmodule

/* tb/sd_card_model.sv */
`timescale 1ns/1ps

module sd_card_model (
	input  logic sd_clk,
	inout  wire sd_cmd,
	inout  wire [3:0] sd_dat,
	input  logic hc_card,
	input  logic silent_cmd8,
	input  logic [1:0] busy_count,
	input  logic withhold_data,
	input  logic [15:0] rca
);

	logic cmd_oe;
	logic cmd_bit;
	logic [3:0] dat_out;
	logic app_cmd;
	int busy_left;
	int log_count;
	logic [5:0] log_index [0:255];
	logic [31:0] log_arg [0:255];
	logic log_ok [0:255];  // crc7, start and end bits all good
	logic [7:0] block_data [0:sd_pkg::block_bytes-1];

	assign sd_cmd = cmd_oe ? cmd_bit : 1'bz;
	pullup (sd_cmd);
	assign sd_dat = dat_out;  // card holds DAT high while idle

	function automatic logic [6:0] crc7(input logic [39:0] bits);
		logic [6:0] c;
		logic fb;
		c = '0;
		for (int i = 39; i >= 0; i--)
		begin
			fb = bits[i] ^ c[6];
			c = {c[5:0], 1'b0};
			if (fb)
				c = c ^ 7'h09;
		end
		return c;
	endfunction

	function automatic logic [135:0] r48(input logic [5:0] idx, input logic [31:0] arg);
		logic [39:0] head;
		head = {2'b00, idx, arg};
		return {88'h0, head, crc7(head), 1'b1};
	endfunction

	task automatic get_frame(output logic [47:0] frame);
		frame = '1;
		@(posedge sd_clk);
		while (sd_cmd !== 1'b0)
			@(posedge sd_clk);
		frame[47] = 1'b0;
		for (int i = 46; i >= 0; i--)
		begin
			@(posedge sd_clk);
			frame[i] = sd_cmd;
		end
	endtask

	task automatic send_rsp(input logic [135:0] bits, input int len);
		repeat (2) @(negedge sd_clk);  // NCR gap
		for (int i = len - 1; i >= 0; i--)
		begin
			@(negedge sd_clk);
			cmd_oe = 1'b1;
			cmd_bit = bits[i];
		end
		@(negedge sd_clk);
		cmd_oe = 1'b0;
	endtask

	task automatic fill_block(input logic [31:0] arg);
		logic [15:0] s;
		s = arg[15:0] ^ arg[31:16] ^ 16'hace1;
		if (s == 16'h0)
			s = 16'h1;
		for (int i = 0; i < sd_pkg::block_bytes; i++)
		begin
			repeat (8) s = s[0] ? (s >> 1) ^ 16'hb400 : s >> 1;
			block_data[i] = s[7:0];
		end
	endtask

	task automatic send_block();
		repeat (4) @(negedge sd_clk);
		dat_out = 4'h0;  // start bit
		for (int i = 0; i < sd_pkg::block_bytes; i++)
		begin
			@(negedge sd_clk);
			dat_out = block_data[i][7:4];
			@(negedge sd_clk);
			dat_out = block_data[i][3:0];
		end
		repeat (16)
		begin
			@(negedge sd_clk);
			dat_out = 4'h0;  // crc16 field left at zero
		end
		@(negedge sd_clk);
		dat_out = 4'hf;  // end bit, then idle
	endtask

	task automatic serve_cmd(input logic [47:0] frame);
		logic [5:0] idx;
		logic [31:0] arg;
		logic [31:0] ocr;
		logic app;
		idx = frame[45:40];
		arg = frame[39:8];
		app = app_cmd;
		app_cmd = 1'b0;
		if (log_count < 256)
		begin
			log_index[log_count] = idx;
			log_arg[log_count] = arg;
			log_ok[log_count] = (frame[47:46] == 2'b01) && (frame[7:1] == crc7(frame[47:8]))
				&& frame[0];
			log_count++;
		end
		if (idx == 6'd0)
			busy_left = busy_count;  // go idle, no response
		else if (idx == 6'd8)
		begin
			if (!silent_cmd8)
				send_rsp(r48(6'd8, {20'h0, arg[11:0]}), 48);
		end
		else if (idx == 6'd55)
		begin
			app_cmd = 1'b1;
			send_rsp(r48(6'd55, 32'h0000_0120), 48);
		end
		else if (app && idx == 6'd41)
		begin
			ocr = {busy_left == 0, hc_card && arg[30], 6'b0, 24'hff8000};
			if (busy_left > 0)
				busy_left--;
			send_rsp({88'h0, 2'b00, 6'h3f, ocr, 7'h7f, 1'b1}, 48);
		end
		else if (idx == 6'd2)
			send_rsp({2'b00, 6'h3f, 120'h03_5344_5344_3038_4780_1234_5678_0123, 7'h55, 1'b1},
				136);
		else if (idx == 6'd3)
			send_rsp(r48(6'd3, {rca, 16'h0500}), 48);
		else if (idx == 6'd17)
		begin
			fill_block(arg);
			send_rsp(r48(6'd17, 32'h0000_0900), 48);
			if (!withhold_data)
				send_block();
		end
		else
			send_rsp(r48(idx, 32'h0000_0900), 48);  // CMD7 and ACMD6
	endtask

	initial
	begin
		logic [47:0] frame;
		cmd_oe = 1'b0;
		cmd_bit = 1'b1;
		dat_out = 4'hf;
		app_cmd = 1'b0;
		busy_left = 0;
		log_count = 0;
		forever
		begin
			get_frame(frame);
			serve_cmd(frame);
		end
	end

endmodule

/* tb/tb_top.sv */
`timescale 1ns/1ps

module tb_top;

	logic sys_clk;
	logic rst;
	logic init_req;
	logic read_req;
	sd_pkg::block_addr_t block_addr;
	logic card_ready;
	logic card_error;
	logic data_valid;
	logic read_done;
	logic read_error;
	logic sd_clk;
	sd_pkg::sd_byte_t data_byte;
	wire sd_cmd;
	wire [3:0] sd_dat;

	logic hc_card;
	logic silent_cmd8;
	logic [1:0] busy_count;
	logic withhold_data;
	logic [15:0] card_rca;
	logic [15:0] lfsr;
	logic [31:0] rnd;
	logic [31:0] addr;
	int base;

	tb_clock clock_src (.sys_clk, .rst);

	sd_host_top UUT (.sys_clk, .rst, .init_req, .read_req, .block_addr, .card_ready,
		.card_error, .data_valid, .read_done, .read_error, .sd_clk, .data_byte, .sd_cmd,
		.sd_dat);

	sd_card_model card (.sd_clk, .sd_cmd, .sd_dat, .hc_card, .silent_cmd8, .busy_count,
		.withhold_data, .rca(card_rca));

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 16'hb400 : lfsr >> 1;
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic logic [31:0] expected_arg(input logic [31:0] blk, input logic hc);
		return hc ? blk : blk * 32'd512;  // standard cards want byte addresses
	endfunction

	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp)
		begin
			$display("ERROR at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
			$display("Testbench failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("%s at %0t ns", what, $time);
		$display("Testbench failed");
		$fatal(1, "run stopped");
	endtask

	task automatic wait_reset();
		int n;
		n = 0;
		while (rst !== 1'b0)
		begin
			if (n == 100)
				timeout_fail("reset was never released");
			@(negedge sys_clk);
			n++;
		end
	endtask

	// system cycles from one rising sd_clk edge to the next
	task automatic check_clk_period(input int exp);
		int n;
		int rises;
		int len;
		logic prev;
		n = 0;
		rises = 0;
		len = 0;
		prev = sd_clk;
		while (rises < 2)
		begin
			if (n == 1000)
				timeout_fail("sd_clk stopped toggling");
			@(negedge sys_clk);
			n++;
			if (rises == 1)
				len++;
			if (sd_clk === 1'b1 && prev === 1'b0)
				rises++;
			prev = sd_clk;
		end
		check_val("sd_clk period", len, exp);
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		while (card_ready !== 1'b1)
		begin
			if (card_error === 1'b1)
				timeout_fail("card_error went high during identification");
			if (n == 1500000)
				timeout_fail("timed out waiting for card_ready");
			@(negedge sys_clk);
			n++;
		end
	endtask

	task automatic expect_cmd(input int k, input logic [5:0] idx, input logic [31:0] arg);
		check_val($sformatf("log[%0d] index", k), card.log_index[k], idx);
		check_val($sformatf("log[%0d] arg", k), card.log_arg[k], arg);
		check_val($sformatf("log[%0d] crc7/end", k), card.log_ok[k], 1);
	endtask

	task automatic check_init(input int first, input logic v2, input int busy);
		int k;
		k = first;
		expect_cmd(k, 6'd0, 32'h0);
		expect_cmd(k + 1, 6'd8, 32'h1aa);
		k = k + 2;
		if (!v2)
		begin
			expect_cmd(k, 6'd0, 32'h0);  // v1 path repeats CMD0
			k++;
		end
		for (int i = 0; i <= busy; i++)
		begin
			expect_cmd(k, 6'd55, 32'h0);
			expect_cmd(k + 1, 6'd41, v2 ? 32'h40ff_8000 : 32'h00ff_8000);  // HCS is bit 30
			k = k + 2;
		end
		expect_cmd(k, 6'd2, 32'h0);
		expect_cmd(k + 1, 6'd3, 32'h0);
		expect_cmd(k + 2, 6'd7, {card_rca, 16'h0});
		expect_cmd(k + 3, 6'd55, {card_rca, 16'h0});
		expect_cmd(k + 4, 6'd6, 32'd2);
		check_val("command count", card.log_count, k + 5);
		check_val("card_error", card_error, 0);
	endtask

	task automatic restart_card();
		init_req = 1'b1;
		@(negedge sys_clk);
		init_req = 1'b0;
		check_val("card_ready", card_ready, 0);
	endtask

	task automatic do_read(input logic [31:0] blk, input logic [31:0] exp_arg,
		input logic exp_err);
		int n;
		int bytes;
		int first;
		first = card.log_count;
		read_req = 1'b1;
		block_addr = blk;
		@(negedge sys_clk);
		read_req = 1'b0;
		check_val("card_ready", card_ready, 0);
		n = 0;
		bytes = 0;
		while (read_done !== 1'b1)
		begin
			if (data_valid === 1'b1)
			begin
				check_val($sformatf("data_byte[%0d]", bytes), data_byte, card.block_data[bytes]);
				bytes++;
			end
			if (n == 400000)
				timeout_fail("timed out waiting for read_done");
			@(negedge sys_clk);
			n++;
		end
		check_val("read_error", read_error, exp_err);
		check_val("card_ready", card_ready, 1);
		check_val("data_valid count", bytes, exp_err ? 0 : sd_pkg::block_bytes);
		expect_cmd(first, 6'd17, exp_arg);
		check_val("command count", card.log_count, first + 1);
	endtask

	initial
	begin
		lfsr = 16'd28947;
		init_req = 1'b0;
		read_req = 1'b0;
		block_addr = '0;
		hc_card = 1'b0;
		silent_cmd8 = 1'b0;
		withhold_data = 1'b0;
		rnd = rand_bits(2);
		busy_count = rnd[1:0];
		rnd = rand_bits(16);
		card_rca = rnd[15:0];
		wait_reset();
		check_clk_period(sd_pkg::id_clk_div);

		// standard capacity, version 2
		wait_ready();
		check_init(0, 1'b1, busy_count);
		check_clk_period(2);
		repeat (2)
		begin
			addr = rand_bits(23);
			do_read(addr, expected_arg(addr, 1'b0), 1'b0);
		end

		// high capacity
		hc_card = 1'b1;
		rnd = rand_bits(2);
		busy_count = rnd[1:0];
		base = card.log_count;
		restart_card();
		check_clk_period(sd_pkg::id_clk_div);
		wait_ready();
		check_init(base, 1'b1, busy_count);
		addr = rand_bits(32);
		do_read(addr, expected_arg(addr, 1'b1), 1'b0);

		// version 1, no CMD8 answer
		hc_card = 1'b0;
		silent_cmd8 = 1'b1;
		rnd = rand_bits(2);
		busy_count = rnd[1:0];
		base = card.log_count;
		restart_card();
		wait_ready();
		check_init(base, 1'b0, busy_count);
		addr = rand_bits(23);
		do_read(addr, expected_arg(addr, 1'b0), 1'b0);

		// no data start bit
		withhold_data = 1'b1;
		addr = rand_bits(23);
		do_read(addr, expected_arg(addr, 1'b0), 1'b1);

		$display("Testbench passed");
		$finish;
	end

endmodule

/* list.f */
common/sd_pkg.sv
src/sd_clock_gen.sv
sd_cmd/sd_cmd_tx.sv
sd_cmd/sd_cmd_rx.sv
sd_dat/sd_dat_rx.sv
src/sd_card_ctrl.sv
src/sd_host_top.sv
tb/tb_clock.sv
tb/sd_card_model.sv
tb/tb_top.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module tb_top -f list.f -Mdir obj_dir -o tb_top

run: compile
	@out=$$(./obj_dir/tb_top); echo "$$out"; echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf obj_dir
